// ==== compile.f ====
source/zbuf_pkg.sv
source/scale_lane_array.sv
source/z_buffer.sv
source/z_tile_ctrl.sv
source/z_tile_engine.sv
dv/z_tile_engine_assert.sv
dv/z_tile_engine_tb.sv

// ==== Bender.yml ====
package:
  name: z_tile_engine

sources:
  - files:
      - source/zbuf_pkg.sv
      - source/scale_lane_array.sv
      - source/z_buffer.sv
      - source/z_tile_ctrl.sv
      - source/z_tile_engine.sv
  - target: test
    files:
      - dv/z_tile_engine_assert.sv
      - dv/z_tile_engine_tb.sv

// ==== dv/z_tile_engine_tb.sv ====
// ########################################
// Z tile engine testbench
// Wishbone memory model, reference model
// and checks for five tile jobs
// ########################################

`timescale 1ns/1ps

module z_tile_engine_tb import zbuf_pkg::*; ();

  localparam int MEM_ROWS     = 64;   // Memory model depth in rows
  localparam int DONE_TIMEOUT = 400;  // Cycles allowed for one job
  localparam int ACK_TIMEOUT  = 100;

  // Base addresses of the Y and Z regions
  localparam logic [ADDR_W-1:0] Y_A = 32'h0000_0040;
  localparam logic [ADDR_W-1:0] Y_B = 32'h0000_0080;
  localparam logic [ADDR_W-1:0] Y_C = 32'h0000_00C0;
  localparam logic [ADDR_W-1:0] Z_A = 32'h0000_0100;
  localparam logic [ADDR_W-1:0] Z_B = 32'h0000_0140;
  localparam logic [ADDR_W-1:0] Z_C = 32'h0000_0180;

  logic              clk_i;
  logic              rst_i;
  logic              start_i;
  logic [ADDR_W-1:0] y_addr_i;
  logic [ADDR_W-1:0] z_addr_i;
  logic [ROWS_W-1:0] rows_i;
  logic [COLS_W-1:0] cols_i;
  elem_t             alpha_i;
  elem_t             beta_i;
  logic              busy_o;
  logic              done_o;
  logic              wb_cyc_o;
  logic              wb_stb_o;
  logic              wb_we_o;
  logic [ADDR_W-1:0] wb_adr_o;
  row_t              wb_dat_o;
  row_t              wb_dat_i;
  logic              wb_ack_i;

  row_t              mem [MEM_ROWS];
  row_t              exp_tile [TILE_W];  // Expected Z rows of the running job
  logic [ADDR_W-1:0] y_base;
  logic [ADDR_W-1:0] z_base;
  integer            seed = 40;
  int                max_wait = 0;       // Upper bound of ack wait states
  int                rd_count = 0;
  int                wr_count = 0;
  int                done_count = 0;
  int                err_count = 0;
  int                test_errs = 0;      // Errors seen before the running test
  int                test_num = 0;
  int                tests_ok = 0;
  int                tests_bad = 0;

  z_tile_engine dut0 (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .start_i  (start_i),
    .y_addr_i (y_addr_i),
    .z_addr_i (z_addr_i),
    .rows_i   (rows_i),
    .cols_i   (cols_i),
    .alpha_i  (alpha_i),
    .beta_i   (beta_i),
    .busy_o   (busy_o),
    .done_o   (done_o),
    .wb_cyc_o (wb_cyc_o),
    .wb_stb_o (wb_stb_o),
    .wb_we_o  (wb_we_o),
    .wb_adr_o (wb_adr_o),
    .wb_dat_o (wb_dat_o),
    .wb_dat_i (wb_dat_i),
    .wb_ack_i (wb_ack_i)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic int mem_idx(input logic [ADDR_W-1:0] adr);
    return int'((adr / ROW_BYTES) % MEM_ROWS);
  endfunction

  // Reference model of z = alpha*y + beta with zero outside the valid extent
  function automatic row_t expected_row(input row_t y, input int w, input elem_t alpha,
                                        input elem_t beta, input int rows, input int cols);
    row_t  r;
    elem_t v;
    int    eff_rows;
    int    eff_cols;
    eff_rows = (rows == 0) ? TILE_W : rows;
    eff_cols = (cols == 0) ? TILE_D : cols;
    for (int d = 0; d < TILE_D; d++) begin
      v    = (w < eff_rows && d < eff_cols) ? y[d] : '0;
      r[d] = alpha * v + beta;  // Wraps at 16 bits
    end
    return r;
  endfunction

  function automatic int total_errors();
    return err_count + dut0.u_assert.fail_cnt;
  endfunction

  task automatic check_row(input row_t got, input row_t exp, input string what);
    if (got !== exp) begin
      $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      err_count++;
    end
  endtask

  task automatic check_addr(input logic [ADDR_W-1:0] got, input logic [ADDR_W-1:0] exp,
                            input string what);
    if (got !== exp) begin
      $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      err_count++;
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
      err_count++;
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      $display("Error at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
      err_count++;
    end
  endtask

  // Wishbone slave that answers after 0 to max_wait cycles
  initial begin : memory_model
    int waits;
    waits    = -1;
    wb_ack_i = 1'b0;
    wb_dat_i = '0;
    forever begin
      @(negedge clk_i);
      if (rst_i || !(wb_cyc_o && wb_stb_o)) begin
        wb_ack_i = 1'b0;
        waits    = -1;
      end else begin
        if (waits < 0) begin
          waits = $unsigned($random(seed)) % (max_wait + 1);  // New transfer
        end
        if (waits == 0) begin
          wb_ack_i = 1'b1;
          if (wb_we_o) begin
            mem[mem_idx(wb_adr_o)] = wb_dat_o;
          end else begin
            wb_dat_i = mem[mem_idx(wb_adr_o)];
          end
          waits = -1;
        end else begin
          wb_ack_i = 1'b0;
          waits--;
        end
      end
    end
  end

  // Compares every completed transfer against the running job
  initial begin : bus_monitor
    forever begin
      @(posedge clk_i);
      if (!rst_i && wb_cyc_o && wb_stb_o && wb_ack_i) begin
        // All TILE_W reads come before the first write
        check_bit(wb_we_o, rd_count >= TILE_W, "wb_we_o");
        if (wb_we_o && wr_count >= TILE_W) begin
          $display("A write beyond the last tile row happened at %0d ns", $time);
          err_count++;
        end else if (wb_we_o) begin
          check_addr(wb_adr_o, z_base + ADDR_W'(wr_count * ROW_BYTES), "write address");
          check_row(wb_dat_o, exp_tile[wr_count], "write data");
        end else begin
          check_addr(wb_adr_o, y_base + ADDR_W'(rd_count * ROW_BYTES), "read address");
        end
        if (wb_we_o) begin
          wr_count++;
        end else begin
          rd_count++;
        end
      end
    end
  end

  initial begin : done_counter
    forever begin
      @(posedge clk_i);
      if (done_o === 1'b1) begin
        done_count++;
      end
    end
  end

  task automatic fill_y(input logic [ADDR_W-1:0] base);
    for (int k = 0; k < TILE_W; k++) begin
      mem[mem_idx(base + ADDR_W'(k * ROW_BYTES))] = {$random(seed), $random(seed)};
    end
  endtask

  // Called on a falling edge and returns one cycle after the start pulse
  task automatic start_job(input logic [ADDR_W-1:0] y_adr, input logic [ADDR_W-1:0] z_adr,
                           input int rows, input int cols, input elem_t alpha,
                           input elem_t beta);
    for (int w = 0; w < TILE_W; w++) begin
      exp_tile[w] = expected_row(mem[mem_idx(y_adr + ADDR_W'(w * ROW_BYTES))], w, alpha,
                                 beta, rows, cols);
    end
    y_base   = y_adr;
    z_base   = z_adr;
    rd_count = 0;
    wr_count = 0;
    y_addr_i = y_adr;
    z_addr_i = z_adr;
    rows_i   = ROWS_W'(rows);
    cols_i   = COLS_W'(cols);
    alpha_i  = alpha;
    beta_i   = beta;
    start_i  = 1'b1;
    @(negedge clk_i);
    start_i  = 1'b0;
    check_bit(busy_o, 1'b1, "busy_o after start");
  endtask

  task automatic wait_reads(input int n, input string what);
    int cycles;
    cycles = 0;
    while (rd_count < n && cycles < ACK_TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (rd_count < n) begin
      $display("The read ack for %s never came", what);
      err_count++;
    end
  endtask

  // Returns on the falling edge where done_o is high
  task automatic finish_job(input string what);
    int cycles;
    cycles = 0;
    while (done_o !== 1'b1 && cycles < DONE_TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (done_o !== 1'b1) begin
      $display("done_o never rose for the %s job", what);
      err_count++;
    end else begin
      check_bit(busy_o, 1'b0, "busy_o with done_o");
    end
    check_count(rd_count, TILE_W, "read count");
    check_count(wr_count, TILE_W, "write count");
  endtask

  task automatic begin_test();
    test_errs = total_errors();
  endtask

  task automatic end_test(input string name);
    test_num++;
    if (total_errors() == test_errs) begin
      tests_ok++;
      $display("Test %0d (%s): ok", test_num, name);
    end else begin
      tests_bad++;
      $display("Test %0d (%s): FAILED", test_num, name);
    end
  endtask

  initial begin : main
    elem_t alpha;
    elem_t beta;
    int    done_before;
    rst_i    = 1'b1;
    start_i  = 1'b0;
    y_addr_i = '0;
    z_addr_i = '0;
    rows_i   = '0;
    cols_i   = '0;
    alpha_i  = '0;
    beta_i   = '0;
    for (int i = 0; i < MEM_ROWS; i++) begin
      mem[i] = {TILE_D{elem_t'(i * 16'h1357 + 16'h0F0F)}};  // Address dependent fill
    end
    repeat (2) @(negedge clk_i);
    rst_i = 1'b0;

    // Full tile from a memory without wait states
    begin_test();
    fill_y(Y_A);
    alpha       = $random(seed);
    beta        = $random(seed);
    done_before = done_count;
    start_job(Y_A, Z_A, 0, 0, alpha, beta);
    finish_job("full tile");
    repeat (2) @(negedge clk_i);
    check_count(done_count, done_before + 1, "done pulse count");
    end_test("full tile, no wait states");

    // Same job again with random ack delays
    begin_test();
    max_wait    = 3;
    done_before = done_count;
    start_job(Y_A, Z_A, 0, 0, alpha, beta);
    finish_job("delayed");
    repeat (2) @(negedge clk_i);
    check_count(done_count, done_before + 1, "done pulse count");
    end_test("full tile, random wait states");

    begin_test();
    fill_y(Y_B);
    alpha       = $random(seed);
    beta        = $random(seed);
    done_before = done_count;
    start_job(Y_B, Z_B, 3, 2, alpha, beta);
    finish_job("leftover");
    repeat (2) @(negedge clk_i);
    check_count(done_count, done_before + 1, "done pulse count");
    end_test("leftover tile 3x2");

    // Two jobs back to back with an extra start that must be dropped
    begin_test();
    fill_y(Y_B);
    fill_y(Y_C);
    alpha       = $random(seed);
    beta        = $random(seed);
    done_before = done_count;
    start_job(Y_B, Z_B, 0, 0, alpha, beta);
    wait_reads(1, "the first job");
    start_i = 1'b1;
    @(negedge clk_i);
    start_i = 1'b0;
    finish_job("first back-to-back");
    alpha = $random(seed);
    beta  = $random(seed);
    start_job(Y_C, Z_C, 2, 3, alpha, beta);
    finish_job("second back-to-back");
    repeat (3) @(negedge clk_i);
    check_count(done_count, done_before + 2, "done pulse count");
    end_test("back-to-back jobs");

    begin_test();
    fill_y(Y_A);
    alpha = $random(seed);
    beta  = $random(seed);
    start_job(Y_A, Z_C, 0, 0, alpha, beta);
    wait_reads(2, "the job to be reset");
    rst_i = 1'b1;
    repeat (2) @(negedge clk_i);
    rst_i = 1'b0;
    check_bit(wb_cyc_o, 1'b0, "wb_cyc_o after reset");
    check_bit(wb_stb_o, 1'b0, "wb_stb_o after reset");
    check_bit(busy_o, 1'b0, "busy_o after reset");
    check_bit(done_o, 1'b0, "done_o after reset");
    done_before = done_count;
    start_job(Y_A, Z_B, 0, 0, alpha, beta);
    finish_job("post-reset");
    repeat (2) @(negedge clk_i);
    check_count(done_count, done_before + 1, "done pulse count");
    end_test("reset during read phase");

    $display("Tests: %0d passed, %0d failed, %0d errors", tests_ok, tests_bad,
             total_errors());
    if (tests_bad == 0 && total_errors() == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule : z_tile_engine_tb

// ==== dv/z_tile_engine_assert.sv ====
// ########################################
// Z tile engine assertions
// Wishbone master rules and done pulse
// ########################################

`timescale 1ns/1ps

module z_tile_engine_assert import zbuf_pkg::*; (
  input logic              clk_i,
  input logic              rst_i,
  input logic              busy_i,
  input logic              done_i,
  input logic              cyc_i,
  input logic              stb_i,
  input logic              we_i,
  input logic              ack_i,
  input logic [ADDR_W-1:0] adr_i,
  input row_t              wdat_i
);

  int fail_cnt = 0;  // Read by the testbench

  assert property (@(posedge clk_i) disable iff (rst_i) stb_i |-> cyc_i)
    else begin $error("stb high without cyc"); fail_cnt++; end

  // A stalled transfer holds its address, direction and write data
  assert property (@(posedge clk_i) disable iff (rst_i)
                   (stb_i && !ack_i) |=> $stable(adr_i) && $stable(we_i)
                                         && (!we_i || $stable(wdat_i)))
    else begin $error("transfer changed before ack"); fail_cnt++; end

  assert property (@(posedge clk_i) disable iff (rst_i) done_i |=> !done_i)
    else begin $error("done longer than one cycle"); fail_cnt++; end

  assert property (@(posedge clk_i) disable iff (rst_i) done_i |-> !cyc_i)
    else begin $error("done while cyc high"); fail_cnt++; end

  assert property (@(posedge clk_i) disable iff (rst_i) !busy_i |-> !cyc_i && !stb_i)
    else begin $error("bus active while not busy"); fail_cnt++; end

endmodule : z_tile_engine_assert

bind z_tile_engine z_tile_engine_assert u_assert (
  .clk_i  (clk_i),
  .rst_i  (rst_i),
  .busy_i (busy_o),
  .done_i (done_o),
  .cyc_i  (wb_cyc_o),
  .stb_i  (wb_stb_o),
  .we_i   (wb_we_o),
  .ack_i  (wb_ack_i),
  .adr_i  (wb_adr_o),
  .wdat_i (wb_dat_o)
);

// ==== source/z_tile_engine.sv ====
// ########################################
// Z tile engine
// Top level joining the controller, the
// Z buffer and the scaling lanes
// ########################################

`timescale 1ns/1ps

module z_tile_engine import zbuf_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              start_i,
  input  logic [ADDR_W-1:0] y_addr_i,
  input  logic [ADDR_W-1:0] z_addr_i,
  input  logic [ROWS_W-1:0] rows_i,
  input  logic [COLS_W-1:0] cols_i,
  input  elem_t             alpha_i,
  input  elem_t             beta_i,
  output logic              busy_o,
  output logic              done_o,
  output logic              wb_cyc_o,
  output logic              wb_stb_o,
  output logic              wb_we_o,
  output logic [ADDR_W-1:0] wb_adr_o,
  output row_t              wb_dat_o,
  input  row_t              wb_dat_i,
  input  logic              wb_ack_i
);

  logic               clear;
  logic               load;
  logic               shift;
  logic               store;
  logic               loaded;
  logic               shifted;
  logic               empty;
  elem_t [TILE_W-1:0] y_col;  // Buffer to lanes
  elem_t [TILE_W-1:0] z_col;  // Lanes back to buffer

  z_tile_ctrl u_ctrl (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .start_i   (start_i),
    .y_addr_i  (y_addr_i),
    .z_addr_i  (z_addr_i),
    .wb_ack_i  (wb_ack_i),
    .loaded_i  (loaded),
    .shifted_i (shifted),
    .empty_i   (empty),
    .busy_o    (busy_o),
    .done_o    (done_o),
    .wb_cyc_o  (wb_cyc_o),
    .wb_stb_o  (wb_stb_o),
    .wb_we_o   (wb_we_o),
    .wb_adr_o  (wb_adr_o),
    .clear_o   (clear),
    .load_o    (load),
    .shift_o   (shift),
    .store_o   (store)
  );

  z_buffer u_zbuf (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .clear_i   (clear),
    .load_i    (load),
    .shift_i   (shift),
    .store_i   (store),
    .rows_i    (rows_i),
    .cols_i    (cols_i),
    .y_row_i   (wb_dat_i),
    .z_col_i   (z_col),
    .y_col_o   (y_col),
    .z_row_o   (wb_dat_o),  // Head row goes straight to the bus
    .loaded_o  (loaded),
    .shifted_o (shifted),
    .empty_o   (empty)
  );

  scale_lane_array u_lanes (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .en_i    (shift),
    .y_col_i (y_col),
    .alpha_i (alpha_i),
    .beta_i  (beta_i),
    .z_col_o (z_col)
  );

endmodule : z_tile_engine

// ==== source/z_tile_ctrl.sv ====
// ########################################
// Z tile controller
// Job FSM and Wishbone classic master for
// the read, shift and write phases
// ########################################

`timescale 1ns/1ps

module z_tile_ctrl import zbuf_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              start_i,
  input  logic [ADDR_W-1:0] y_addr_i,
  input  logic [ADDR_W-1:0] z_addr_i,
  input  logic              wb_ack_i,
  input  logic              loaded_i,
  input  logic              shifted_i,
  input  logic              empty_i,
  output logic              busy_o,
  output logic              done_o,
  output logic              wb_cyc_o,
  output logic              wb_stb_o,
  output logic              wb_we_o,
  output logic [ADDR_W-1:0] wb_adr_o,
  output logic              clear_o,
  output logic              load_o,
  output logic              shift_o,
  output logic              store_o
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_CLEAR,
    ST_READ,
    ST_SHIFT,
    ST_WRITE,
    ST_FINISH
  } state_e;

  state_e            state_q;
  state_e            state_d;
  logic [ADDR_W-1:0] adr_q;
  logic              accept;  // A new job is taken

  // Start is only seen while not busy
  assign accept = (state_q == ST_IDLE || state_q == ST_FINISH) && start_i;

  // Next state, phase ends come from the buffer flags
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:   if (accept) state_d = ST_CLEAR;
      ST_CLEAR:  state_d = ST_READ;
      ST_READ:   if (loaded_i) state_d = ST_SHIFT;
      ST_SHIFT:  if (shifted_i) state_d = ST_WRITE;
      ST_WRITE:  if (empty_i) state_d = ST_FINISH;
      ST_FINISH: state_d = accept ? ST_CLEAR : ST_IDLE;
      default:   state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Bus address steps by one row on every ack
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      adr_q <= '0;
    end else if (accept) begin
      adr_q <= y_addr_i;
    end else if (state_q == ST_SHIFT && shifted_i) begin
      adr_q <= z_addr_i;  // Write phase starts at the Z base
    end else if ((state_q == ST_READ || state_q == ST_WRITE) && wb_ack_i) begin
      adr_q <= adr_q + ADDR_W'(ROW_BYTES);
    end
  end

  // Bus signals held until ack
  assign wb_cyc_o = (state_q == ST_READ) || (state_q == ST_WRITE);
  assign wb_stb_o = wb_cyc_o;
  assign wb_we_o  = (state_q == ST_WRITE);
  assign wb_adr_o = adr_q;

  // Buffer strobes
  assign clear_o = (state_q == ST_CLEAR);
  assign load_o  = (state_q == ST_READ) && wb_ack_i;   // Read data valid
  assign shift_o = (state_q == ST_SHIFT);
  assign store_o = (state_q == ST_WRITE) && wb_ack_i;  // Row accepted

  // Status
  assign busy_o = (state_q != ST_IDLE) && (state_q != ST_FINISH);
  assign done_o = (state_q == ST_FINISH);

endmodule : z_tile_ctrl

// ==== source/z_buffer.sv ====
// ########################################
// Z buffer
// Holds the tile, loads Y rows, shifts
// columns through the lanes and presents
// result rows for storing
// ########################################

`timescale 1ns/1ps

module z_buffer import zbuf_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     clear_i,
  input  logic                     load_i,
  input  logic                     shift_i,
  input  logic                     store_i,
  input  logic [ROWS_W-1:0]        rows_i,
  input  logic [COLS_W-1:0]        cols_i,
  input  row_t                     y_row_i,
  input  elem_t [TILE_W-1:0]       z_col_i,
  output elem_t [TILE_W-1:0]       y_col_o,
  output row_t                     z_row_o,
  output logic                     loaded_o,
  output logic                     shifted_o,
  output logic                     empty_o
);

  // Column-major storage, element d of a row sits in column TILE_D-1-d
  elem_t [TILE_D-1:0][TILE_W-1:0] zbuf_q;

  logic [ROW_IDX_W-1:0]   ld_cnt_q;  // Next row to load
  logic [SHIFT_CNT_W-1:0] sh_cnt_q;  // Shifts done in this phase
  logic [ROW_IDX_W-1:0]   st_cnt_q;  // Rows stored so far

  logic [ROWS_W-1:0] eff_rows;
  logic [COLS_W-1:0] eff_cols;
  logic              ld_last;
  logic              sh_last;
  logic              st_last;

  // A zero count means the full tile
  assign eff_rows = (rows_i == '0) ? ROWS_W'(TILE_W) : rows_i;
  assign eff_cols = (cols_i == '0) ? COLS_W'(TILE_D) : cols_i;

  assign ld_last = (ld_cnt_q == ROW_IDX_W'(TILE_W - 1));
  assign sh_last = (sh_cnt_q == SHIFT_CNT_W'(SHIFT_N - 1));
  assign st_last = (st_cnt_q == ROW_IDX_W'(TILE_W - 1));

  // Flags fire together with the strobe that completes the phase
  assign loaded_o  = load_i  && ld_last;
  assign shifted_o = shift_i && sh_last;
  assign empty_o   = store_i && st_last;

  // Phase counters
  always_ff @(posedge clk_i) begin
    if (rst_i || clear_i) begin
      ld_cnt_q <= '0;
      sh_cnt_q <= '0;
      st_cnt_q <= '0;
    end else begin
      if (load_i) begin
        ld_cnt_q <= ld_last ? '0 : ld_cnt_q + 1'b1;
      end
      if (shift_i) begin
        sh_cnt_q <= sh_last ? '0 : sh_cnt_q + 1'b1;
      end
      if (store_i) begin
        st_cnt_q <= st_last ? '0 : st_cnt_q + 1'b1;
      end
    end
  end

  // Tile storage
  always_ff @(posedge clk_i) begin
    if (rst_i || clear_i) begin
      zbuf_q <= '0;
    end else if (load_i) begin
      for (int d = 0; d < TILE_D; d++) begin
        // Outside the valid extent the element is padded with zero
        if (COLS_W'(d) < eff_cols && ROWS_W'(ld_cnt_q) < eff_rows) begin
          zbuf_q[TILE_D-1-d][ld_cnt_q] <= y_row_i[d];
        end else begin
          zbuf_q[TILE_D-1-d][ld_cnt_q] <= '0;
        end
      end
    end else if (shift_i) begin
      zbuf_q[0] <= z_col_i;  // Results come back in at column 0
      for (int d = 1; d < TILE_D; d++) begin
        zbuf_q[d] <= zbuf_q[d-1];
      end
    end else if (store_i) begin
      // Rows move up so row 0 is always the next to write
      for (int d = 0; d < TILE_D; d++) begin
        for (int w = 0; w < TILE_W - 1; w++) begin
          zbuf_q[d][w] <= zbuf_q[d][w+1];
        end
        zbuf_q[d][TILE_W-1] <= '0;
      end
    end
  end

  // Last column feeds the lanes
  assign y_col_o = zbuf_q[TILE_D-1];

  // Row 0, reassembled in element order
  always_comb begin
    for (int d = 0; d < TILE_D; d++) begin
      z_row_o[d] = zbuf_q[TILE_D-1-d][0];
    end
  end

endmodule : z_buffer

// ==== source/scale_lane_array.sv ====
// ########################################
// Scale lane array
// TILE_W lanes computing alpha*y + beta in
// two stages, all stalling together
// ########################################

`timescale 1ns/1ps

module scale_lane_array import zbuf_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               en_i,
  input  elem_t [TILE_W-1:0] y_col_i,
  input  elem_t              alpha_i,
  input  elem_t              beta_i,
  output elem_t [TILE_W-1:0] z_col_o
);

  elem_t [TILE_W-1:0] mul_q;  // Product stage
  elem_t [TILE_W-1:0] sum_q;  // Add stage
  elem_t [TILE_W-1:0] mul_d;
  elem_t [TILE_W-1:0] sum_d;

  // Arithmetic wraps modulo 2^ELEM_W
  always_comb begin
    for (int w = 0; w < TILE_W; w++) begin
      mul_d[w] = alpha_i * y_col_i[w];
      sum_d[w] = mul_q[w] + beta_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mul_q <= '0;
      sum_q <= '0;
    end else if (en_i) begin  // Both stages advance only on a shift
      mul_q <= mul_d;
      sum_q <= sum_d;
    end
  end

  assign z_col_o = sum_q;

endmodule : scale_lane_array

// ==== source/zbuf_pkg.sv ====
// ########################################
// Z tile engine package
// Element, row and tile sizes, lane depth
// and the element and row types
// ########################################

package zbuf_pkg;

  // Element and tile geometry
  localparam int unsigned ELEM_W    = 16;
  localparam int unsigned TILE_D    = 4;               // Elements per row
  localparam int unsigned TILE_W    = 4;               // Rows per tile, one lane each
  localparam int unsigned ROW_W     = TILE_D * ELEM_W; // Bus width
  localparam int unsigned ROW_BYTES = ROW_W / 8;       // Address step between rows

  // Bus
  localparam int unsigned ADDR_W = 32;

  // Lane pipeline depth in shift steps
  localparam int unsigned LANE_LAT = 2;

  // Shifts needed so every result lands on its source slot
  localparam int unsigned SHIFT_N     = TILE_D + LANE_LAT;
  localparam int unsigned SHIFT_CNT_W = $clog2(SHIFT_N);

  // Counter and extent widths
  localparam int unsigned ROW_IDX_W = $clog2(TILE_W);
  localparam int unsigned ROWS_W    = $clog2(TILE_W + 1); // Holds the full row count
  localparam int unsigned COLS_W    = $clog2(TILE_D + 1); // Holds the full column count

  typedef logic [ELEM_W-1:0] elem_t;

  // Element d sits at bits d*ELEM_W upward
  typedef elem_t [TILE_D-1:0] row_t;

endpackage : zbuf_pkg
